// ==== files.f ====
+incdir+hw
hw/bicubic_pkg.sv
hw/tap_if.sv
hw/bicubic_weight_regs.sv
hw/tap_window.sv
hw/tap_fifo.sv
hw/bicubic_mult_stage1.sv
hw/bicubic_vector_mult_stage1.sv
hw/bicubic_output_stage.sv
hw/bicubic_row_filter.sv
test/bicubic_row_filter_asserts.sv
test/bicubic_row_filter_tb.sv

// ==== hw/bicubic_config.svh ====
`ifndef BICUBIC_CONFIG_SVH
`define BICUBIC_CONFIG_SVH

// Sample and coefficient widths
`define BICUBIC_PIXEL_W    9
`define BICUBIC_WEIGHT_W   3

// Wide enough for four signed products plus growth
`define BICUBIC_PRODUCT_W  24

`define BICUBIC_FIFO_DEPTH 4  // Tap vectors, power of two

`endif

// ==== hw/bicubic_mult_stage1.sv ====
`timescale 1ns/1ns
`include "bicubic_config.svh"

module bicubic_mult_stage1 #(
    parameter INTER_PRODUCT_WIDTH = 24
) (
    input  logic                           clk,
    input  logic                           ena,
    input  logic [`BICUBIC_WEIGHT_W-1:0]   weight,
    input  logic [`BICUBIC_PIXEL_W-1:0]    pixel,
    output logic [INTER_PRODUCT_WIDTH-1:0] product
);

    localparam int FULL_W = `BICUBIC_WEIGHT_W + `BICUBIC_PIXEL_W;

    logic signed [FULL_W-1:0] full;

    assign full = $signed(weight) * $signed(pixel);

    // Holds the last product while disabled
    always_ff @(posedge clk) begin
        if (ena)
            product <= {{(INTER_PRODUCT_WIDTH - FULL_W){full[FULL_W-1]}}, full};
    end

endmodule

// ==== hw/bicubic_output_stage.sv ====
`timescale 1ns/1ns

module bicubic_output_stage (
    input  logic                        clk,
    input  logic                        reset,
    tap_if.consumer                     taps_in,
    input  bicubic_pkg::weight_vector_t weights,
    output logic                        out_valid,
    input  logic                        out_ready,
    output bicubic_pkg::product_t       inner_product
);
    import bicubic_pkg::*;

    logic ena;

    // Take a vector when the result slot is free or draining
    assign taps_in.ready = !out_valid || out_ready;
    assign ena           = taps_in.valid && taps_in.ready;

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (ena)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // Product registers hold the result while stalled
    bicubic_vector_mult_stage1 #(
        .INTER_PRODUCT_WIDTH ($bits(product_t))
    ) u_vector_mult (
        .clk           (clk),
        .ena           (ena),
        .weight_1      (weights.w1),
        .pixel_1       (taps_in.taps.p1),
        .weight_2      (weights.w2),
        .pixel_2       (taps_in.taps.p2),
        .weight_3      (weights.w3),
        .pixel_3       (taps_in.taps.p3),
        .weight_4      (weights.w4),
        .pixel_4       (taps_in.taps.p4),
        .inner_product (inner_product)
    );

endmodule

// ==== hw/bicubic_pkg.sv ====
`include "bicubic_config.svh"

package bicubic_pkg;

    typedef logic signed [`BICUBIC_PIXEL_W-1:0]   pixel_t;
    typedef logic signed [`BICUBIC_WEIGHT_W-1:0]  weight_t;
    typedef logic signed [`BICUBIC_PRODUCT_W-1:0] product_t;

    // p1 is the oldest sample of the window
    typedef struct packed {
        pixel_t p4;
        pixel_t p3;
        pixel_t p2;
        pixel_t p1;
    } tap_vector_t;

    // w1 lands in the low bits of the APB word
    typedef struct packed {
        weight_t w4;
        weight_t w3;
        weight_t w2;
        weight_t w1;
    } weight_vector_t;

endpackage

// ==== hw/bicubic_row_filter.sv ====
`timescale 1ns/1ns
`include "bicubic_config.svh"

module bicubic_row_filter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  sample_valid,
    output logic                  sample_ready,
    input  bicubic_pkg::pixel_t   sample,
    input  logic                  row_start,
    output logic                  out_valid,
    input  logic                  out_ready,
    output bicubic_pkg::product_t inner_product
);
    import bicubic_pkg::*;

    weight_vector_t weights;

    tap_if win_to_fifo ();
    tap_if fifo_to_out ();

    bicubic_weight_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .weights (weights)
    );

    tap_window u_window (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .row_start    (row_start),
        .sample       (sample),
        .sample_ready (sample_ready),
        .taps_out     (win_to_fifo.producer)
    );

    tap_fifo #(.DEPTH(`BICUBIC_FIFO_DEPTH)) u_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (win_to_fifo.consumer),
        .rd    (fifo_to_out.producer)
    );

    bicubic_output_stage u_out (
        .clk           (clk),
        .reset         (reset),
        .taps_in       (fifo_to_out.consumer),
        .weights       (weights),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .inner_product (inner_product)
    );

endmodule

// ==== hw/bicubic_vector_mult_stage1.sv ====
`timescale 1ns/1ns
`include "bicubic_config.svh"

module bicubic_vector_mult_stage1 #(
    parameter INTER_PRODUCT_WIDTH = 24
) (
    input  logic                           clk,
    input  logic                           ena,
    input  logic [`BICUBIC_WEIGHT_W-1:0]   weight_1,
    input  logic [`BICUBIC_PIXEL_W-1:0]    pixel_1,
    input  logic [`BICUBIC_WEIGHT_W-1:0]   weight_2,
    input  logic [`BICUBIC_PIXEL_W-1:0]    pixel_2,
    input  logic [`BICUBIC_WEIGHT_W-1:0]   weight_3,
    input  logic [`BICUBIC_PIXEL_W-1:0]    pixel_3,
    input  logic [`BICUBIC_WEIGHT_W-1:0]   weight_4,
    input  logic [`BICUBIC_PIXEL_W-1:0]    pixel_4,
    output logic [INTER_PRODUCT_WIDTH-1:0] inner_product
);

    localparam int WW = `BICUBIC_WEIGHT_W;
    localparam int PW = `BICUBIC_PIXEL_W;

    logic [4*WW-1:0]                weight_bus;
    logic [4*PW-1:0]                pixel_bus;
    logic [INTER_PRODUCT_WIDTH-1:0] product [4];
    logic [INTER_PRODUCT_WIDTH-1:0] sum_lo;
    logic [INTER_PRODUCT_WIDTH-1:0] sum_hi;

    assign weight_bus = {weight_4, weight_3, weight_2, weight_1};
    assign pixel_bus  = {pixel_4, pixel_3, pixel_2, pixel_1};

    for (genvar i = 0; i < 4; i++) begin : g_mult
        bicubic_mult_stage1 #(.INTER_PRODUCT_WIDTH(INTER_PRODUCT_WIDTH)) u_mult (
            .clk     (clk),
            .ena     (ena),
            .weight  (weight_bus[i*WW +: WW]),
            .pixel   (pixel_bus[i*PW +: PW]),
            .product (product[i])
        );
    end

    // Two-level adder tree after the product registers
    assign sum_lo        = product[0] + product[1];
    assign sum_hi        = product[2] + product[3];
    assign inner_product = sum_lo + sum_hi;

endmodule

// ==== hw/bicubic_weight_regs.sv ====
`timescale 1ns/1ns

module bicubic_weight_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [3:0]                  paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output bicubic_pkg::weight_vector_t weights
);

    logic access;
    logic addr_hit;
    logic [31:0] weight_word;

    assign access   = psel && penable;
    assign addr_hit = (paddr == 4'd0);

    // No wait states
    assign pready  = access;
    assign pslverr = access && !addr_hit;

    assign weight_word = {{(32 - $bits(weights)){1'b0}}, weights};
    assign prdata      = (psel && addr_hit) ? weight_word : 32'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
        end else if (access && pwrite && addr_hit) begin
            weights <= pwdata[$bits(weights)-1:0];  // Upper bits dropped
        end
    end

endmodule

// ==== hw/tap_fifo.sv ====
`timescale 1ns/1ns

module tap_fifo #(
    parameter int DEPTH = 4
) (
    input  logic    clk,
    input  logic    reset,
    tap_if.consumer wr,
    tap_if.producer rd
);
    import bicubic_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    tap_vector_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             push;
    logic             pop;

    assign wr.ready = (fill != DEPTH[PTR_W:0]);
    assign rd.valid = (fill != '0);
    assign rd.taps  = mem[rd_ptr];  // Head entry, stable until popped

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr.taps;
    end

endmodule

// ==== hw/tap_if.sv ====
`timescale 1ns/1ns

interface tap_if;
    import bicubic_pkg::*;

    logic        valid;
    logic        ready;
    tap_vector_t taps;  // Held while valid and not ready

    modport producer (
        output valid,
        output taps,
        input  ready
    );

    modport consumer (
        input  valid,
        input  taps,
        output ready
    );

endinterface

// ==== hw/tap_window.sv ====
`timescale 1ns/1ns

module tap_window (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic                row_start,
    input  bicubic_pkg::pixel_t sample,
    output logic                sample_ready,
    tap_if.producer             taps_out
);
    import bicubic_pkg::*;

    tap_vector_t window;
    logic [2:0]  count;       // Samples seen this row, stops at 4
    logic [2:0]  count_next;
    logic        vec_valid;
    logic        accept;

    // Stall while a finished vector has not been taken
    assign sample_ready = !vec_valid || taps_out.ready;
    assign accept       = sample_valid && sample_ready;

    always_comb begin
        if (row_start)
            count_next = 3'd1;
        else if (count == 3'd4)
            count_next = 3'd4;
        else
            count_next = count + 3'd1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= 3'd0;
            vec_valid <= 1'b0;
        end else if (accept) begin
            count     <= count_next;
            vec_valid <= (count_next == 3'd4);
        end else if (taps_out.ready) begin
            vec_valid <= 1'b0;
        end
    end

    // Stale entries after a row start are pushed out before count reaches 4
    always_ff @(posedge clk) begin
        if (accept) begin
            window.p1 <= window.p2;
            window.p2 <= window.p3;
            window.p3 <= window.p4;
            window.p4 <= sample;
        end
    end

    assign taps_out.valid = vec_valid;
    assign taps_out.taps  = window;

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
    --top-module bicubic_row_filter_tb -o sim

out=$(./obj_dir/sim)
echo "$out"

# Exit status follows the pass line
echo "$out" | grep -qx "Verification passed"

// ==== test/bicubic_row_filter_asserts.sv ====
`timescale 1ns/1ns

module bicubic_row_filter_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  out_valid,
    input logic                  out_ready,
    input bicubic_pkg::product_t inner_product
);

    // Result held under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(inner_product))
        else $error("inner_product changed while out_valid waited for out_ready");

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before out_ready took the result");

    assert property (@(posedge clk) reset |=> !out_valid)  // Clean output after reset
        else $error("out_valid high in the cycle after reset");

endmodule

bind bicubic_row_filter bicubic_row_filter_asserts i_asserts (.*);

// ==== test/bicubic_row_filter_tb.sv ====
`timescale 1ns/1ns

module bicubic_row_filter_tb;
    import bicubic_pkg::*;

    localparam int TOTAL_SAMPLES = 55;  // Sum over all tests

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sample_valid;
    logic        sample_ready;
    pixel_t      sample;
    logic        row_start;
    logic        out_valid;
    logic        out_ready;
    product_t    inner_product;

    integer         seed = 64;
    int             value_errors;
    int             other_errors;
    int             out_count;
    weight_vector_t model_w;
    pixel_t         hist[$];      // Current row, oldest first
    product_t       expected[$];

    bicubic_row_filter i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TOTAL_SAMPLES * 20 + 2000) @(posedge clk);
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("Verification failed");
        $finish;
    end

    // Result transfers happen on the rising edge
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            out_count++;
            if (expected.size() == 0) begin
                other_errors++;
                $display("Output at %0t arrived with no expected sum pending", $time);
            end else begin
                check_product("inner_product", inner_product, expected.pop_front());
            end
        end
    end

    task automatic check_product(input string name, input product_t got, input product_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_output_count(input int got, input int exp, input string what);
        if (got != exp) begin
            other_errors++;
            $display("The %s test gave %0d outputs instead of %0d", what, got, exp);
        end
    endtask

    task automatic model_sample(input pixel_t px, input logic start);
        int acc;
        if (start)
            hist.delete();
        hist.push_back(px);
        if (hist.size() > 4)
            void'(hist.pop_front());
        if (hist.size() == 4) begin
            acc = int'(model_w.w1) * int'(hist[0]) + int'(model_w.w2) * int'(hist[1])
                + int'(model_w.w3) * int'(hist[2]) + int'(model_w.w4) * int'(hist[3]);
            expected.push_back(product_t'(acc));
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        if (!pready) begin
            other_errors++;
            $display("pready stayed low in an APB access phase at %0t", $time);
        end
        if (wr && addr == 4'd0)
            model_w = wdata[11:0];  // Only the weight register exists
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_weights(input weight_t w1, input weight_t w2, input weight_t w3,
                               input weight_t w4);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, 4'd0, {20'd0, w4, w3, w2, w1}, rd, err);
    endtask

    task automatic send_sample(input pixel_t px, input logic start);
        @(negedge clk);
        sample_valid = 1'b1;
        sample       = px;
        row_start    = start;
        while (!sample_ready)
            @(negedge clk);
        model_sample(px, start);  // Accepted on the coming edge
        @(posedge clk);
    endtask

    task automatic stop_samples();
        @(negedge clk);
        sample_valid = 1'b0;
        row_start    = 1'b0;
    endtask

    task automatic send_row(input int n, input int restart_at);
        for (int i = 0; i < n; i++)
            send_sample(pixel_t'($random(seed)), i == 0 || i == restart_at);
        stop_samples();
    endtask

    task automatic wait_drain();
        while (expected.size() != 0)
            @(negedge clk);
        repeat (10) @(negedge clk);  // Room for a stray extra output to show up
    endtask

    task automatic test_apb();
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, 4'd0, 32'd0, rd, err);
        check_word("prdata", rd, 32'd0);
        if (err) begin
            other_errors++;
            $display("APB read of address 0 gave pslverr");
        end
        apb_access(1'b1, 4'd0, 32'hDEAD_5A5A, rd, err);
        apb_access(1'b0, 4'd0, 32'd0, rd, err);
        check_word("prdata", rd, 32'h0000_0A5A);
        apb_access(1'b1, 4'd4, 32'h0000_0123, rd, err);
        if (!err) begin
            other_errors++;
            $display("APB write to address 4 gave no pslverr");
        end
        apb_access(1'b0, 4'd0, 32'd0, rd, err);
        check_word("prdata", rd, 32'h0000_0A5A);
    endtask

    task automatic test_row();
        int start;
        start = out_count;
        // Nearest 3-bit fit of the -1 5 5 -1 kernel
        set_weights(weight_t'(-1), weight_t'(3), weight_t'(3), weight_t'(-1));
        send_row(10, 0);
        wait_drain();
        check_output_count(out_count - start, 7, "single row");
    endtask

    task automatic test_restart();
        int start;
        start = out_count;
        send_row(11, 6);  // Six samples, then a new row of five
        wait_drain();
        check_output_count(out_count - start, 5, "row restart");
    endtask

    task automatic test_backpressure();
        int   start;
        logic stalled;
        start   = out_count;
        stalled = 1'b0;
        @(negedge clk);
        out_ready = 1'b0;
        fork
            send_row(20, 0);
            begin
                repeat (40) begin
                    @(negedge clk);
                    stalled |= !sample_ready;
                end
                out_ready = 1'b1;
            end
        join
        wait_drain();
        if (!stalled) begin
            other_errors++;
            $display("sample_ready never dropped while out_ready was held low");
        end
        check_output_count(out_count - start, 17, "back-pressure");
    endtask

    task automatic test_extremes();
        set_weights(weight_t'(-4), weight_t'(3), weight_t'(-4), weight_t'(3));
        for (int i = 0; i < 8; i++)
            send_sample(i[0] ? pixel_t'(255) : pixel_t'(-256), i == 0);
        stop_samples();
        wait_drain();
        set_weights(weight_t'(-4), weight_t'(-4), weight_t'(-4), weight_t'(-4));
        for (int i = 0; i < 6; i++)
            send_sample(pixel_t'(-256), i == 0);
        stop_samples();
        wait_drain();
    endtask

    initial begin
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        sample_valid = 1'b0;
        sample       = '0;
        row_start    = 1'b0;
        out_ready    = 1'b1;
        model_w      = '0;
        value_errors = 0;
        other_errors = 0;
        out_count    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_apb();
        test_row();
        test_restart();
        test_backpressure();
        test_extremes();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
